// File: fsqrt_pkg.sv
package fsqrt_pkg;

    // one root bit per iteration: 24 significand bits, a guard bit and a round bit.
    localparam int sqrt_iterations = 26;

    localparam int float_width = 32;
    localparam int exponent_width = 8;
    localparam int mantissa_width = 23;
    localparam int reg_addr_width = 5;

    typedef logic [float_width-1:0] float_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [exponent_width-1:0] exponent_t;

    // two radicand bits are consumed per root bit.
    typedef logic [2*sqrt_iterations-1:0] radicand_t;
    typedef logic [sqrt_iterations-1:0] root_t;
    typedef logic [sqrt_iterations+1:0] remainder_t;

    typedef enum logic [1:0] {
        CLASS_NORMAL,
        CLASS_ZERO,
        CLASS_INF,
        CLASS_NAN
    } operand_class_t;

    localparam exponent_t exponent_bias = 8'd127;
    localparam exponent_t exponent_max = 8'hff;

    localparam float_t canonical_nan = 32'h7fc0_0000;
    localparam float_t positive_inf = 32'h7f80_0000;

endpackage

// File: fsqrt_exponent.sv
`timescale 1ns/100ps

module fsqrt_exponent
    import fsqrt_pkg::*;
(
    input  logic           clk,
    input  logic           rst,

    input  logic           in_valid,
    output logic           in_ready,
    input  float_t         in_operand,
    input  reg_addr_t      in_reg_addr,

    output logic           exp_valid,
    input  logic           exp_ready,
    output exponent_t      exp_exponent,
    output radicand_t      exp_radicand,
    output operand_class_t exp_class,
    output logic           exp_sign,
    output reg_addr_t      exp_reg_addr
);

    logic sign;
    exponent_t biased_exponent;
    logic [mantissa_width-1:0] mantissa;
    logic [exponent_width:0] exponent_sum;
    operand_class_t operand_class;
    radicand_t radicand;
    logic load;

    assign sign = in_operand[float_width-1];
    assign biased_exponent = in_operand[float_width-2 -: exponent_width];
    assign mantissa = in_operand[mantissa_width-1:0];

    always_comb begin
        if (biased_exponent == '0) begin
            operand_class = CLASS_ZERO; // subnormals are flushed to zero.
        end else if (biased_exponent == exponent_max) begin
            operand_class = (mantissa == '0) ? CLASS_INF : CLASS_NAN;
        end else begin
            operand_class = CLASS_NORMAL;
        end
    end

    // (e + bias) / 2 rounds down, which drops the odd unbiased exponent by one.
    assign exponent_sum = {1'b0, biased_exponent} + {1'b0, exponent_bias};

    // an even biased exponent means an odd unbiased one, so the significand doubles.
    assign radicand = biased_exponent[0]
        ? {2'b01, mantissa, {(2*sqrt_iterations-mantissa_width-2){1'b0}}}
        : {1'b1, mantissa, {(2*sqrt_iterations-mantissa_width-1){1'b0}}};

    assign in_ready = !exp_valid || exp_ready;
    assign load = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_valid <= 1'b0;
        end else if (load) begin
            exp_valid <= 1'b1;
        end else if (exp_ready) begin
            exp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            exp_exponent <= exponent_sum[exponent_width:1];
            exp_radicand <= radicand;
            exp_class <= operand_class;
            exp_sign <= sign;
            exp_reg_addr <= in_reg_addr;
        end
    end

    a_exp_payload_stable: assert property (@(posedge clk) disable iff (rst)
        exp_valid && !exp_ready |=> exp_valid
            && $stable({exp_exponent, exp_radicand, exp_class, exp_sign, exp_reg_addr}));

endmodule

// File: fsqrt_operation.sv
`timescale 1ns/100ps

module fsqrt_operation
    import fsqrt_pkg::*;
(
    input  logic           clk,
    input  logic           rst,

    input  logic           exp_valid,
    output logic           exp_ready,
    input  exponent_t      exp_exponent,
    input  radicand_t      exp_radicand,
    input  operand_class_t exp_class,
    input  logic           exp_sign,
    input  reg_addr_t      exp_reg_addr,

    output logic           op_valid,
    input  logic           op_ready,
    output root_t          op_root,
    output logic           op_sticky,
    output exponent_t      op_exponent,
    output operand_class_t op_class,
    output logic           op_sign,
    output reg_addr_t      op_reg_addr
);

    localparam int counter_width = $clog2(sqrt_iterations + 1);
    localparam logic [counter_width-1:0] last_count = counter_width'(sqrt_iterations);

    logic [counter_width-1:0] counter, next_counter;
    logic enable, consume, produce;
    radicand_t radicand, next_radicand;
    root_t root, next_root;
    remainder_t remainder, next_remainder;

    assign consume = (counter == '0);
    assign produce = (counter == last_count);
    assign enable = (!consume || exp_valid) && (!produce || op_ready);

    assign exp_ready = consume;
    assign op_valid = produce;

    // the consume cycle already performs the first step, so counts 0 to 25 give 26 bits.
    always_comb begin
        radicand_t start_radicand;
        root_t start_root;
        remainder_t start_remainder;
        remainder_t shifted;
        logic [sqrt_iterations+2:0] trial;

        start_radicand = radicand;
        start_root = root;
        start_remainder = remainder;
        if (consume) begin
            start_radicand = exp_radicand;
            start_root = '0;
            start_remainder = '0;
        end

        shifted = {start_remainder[sqrt_iterations-1:0],
                   start_radicand[2*sqrt_iterations-1 -: 2]};
        trial = {1'b0, shifted} - {1'b0, start_root, 2'b01};

        next_radicand = start_radicand << 2;
        if (trial[sqrt_iterations+2]) begin
            next_remainder = shifted; // negative trial, restore.
            next_root = {start_root[sqrt_iterations-2:0], 1'b0};
        end else begin
            next_remainder = trial[sqrt_iterations+1:0];
            next_root = {start_root[sqrt_iterations-2:0], 1'b1};
        end

        next_counter = produce ? '0 : counter + counter_width'(1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
        end else if (enable) begin
            counter <= next_counter;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            radicand <= next_radicand;
            root <= next_root;
            remainder <= next_remainder;
        end
        if (enable && consume) begin
            op_exponent <= exp_exponent;
            op_class <= exp_class;
            op_sign <= exp_sign;
            op_reg_addr <= exp_reg_addr;
        end
    end

    assign op_root = root;
    assign op_sticky = (remainder != '0); // any leftover means the root is not exact.

    a_counter_range: assert property (@(posedge clk) disable iff (rst)
        counter <= last_count);

    a_one_accept_per_pass: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_ready |=> !exp_ready [*sqrt_iterations]);

endmodule

// File: fsqrt_round.sv
`timescale 1ns/100ps

module fsqrt_round
    import fsqrt_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input  logic           clk,
    input  logic           rst,

    input  logic           op_valid,
    output logic           op_ready,
    input  root_t          op_root,
    input  logic           op_sticky,
    input  exponent_t      op_exponent,
    input  operand_class_t op_class,
    input  logic           op_sign,
    input  reg_addr_t      op_reg_addr,

    output logic           out_valid,
    input  logic           out_ready,
    output float_t         out_result,
    output reg_addr_t      out_reg_addr,
    output logic           out_invalid,
    output logic           out_inexact
);

    logic guard_bit, round_bit, round_up;
    logic [mantissa_width+1:0] rounded;
    exponent_t result_exponent;
    logic [mantissa_width-1:0] result_mantissa;
    float_t next_result;
    logic next_invalid, next_inexact;

    assign guard_bit = op_root[1];
    assign round_bit = op_root[0];
    assign round_up = guard_bit && (round_bit || op_sticky || op_root[2]); // ties go to even.
    assign rounded = {1'b0, op_root[sqrt_iterations-1:2]}
                   + {{(mantissa_width+1){1'b0}}, round_up};

    always_comb begin
        if (rounded[mantissa_width+1]) begin
            result_exponent = op_exponent + exponent_t'(1); // carried out to 2.0.
            result_mantissa = rounded[mantissa_width:1];
        end else begin
            result_exponent = op_exponent;
            result_mantissa = rounded[mantissa_width-1:0];
        end
    end

    always_comb begin
        next_result = {1'b0, result_exponent, result_mantissa};
        next_invalid = 1'b0;
        next_inexact = 1'b0;
        if (op_class == CLASS_NAN) begin
            next_result = canonical_nan;
        end else if (op_class == CLASS_ZERO) begin
            next_result = {op_sign, {(float_width-1){1'b0}}};
        end else if (op_sign) begin
            next_result = canonical_nan;
            next_invalid = 1'b1;
        end else if (op_class == CLASS_INF) begin
            next_result = positive_inf;
        end else begin
            next_inexact = guard_bit || round_bit || op_sticky;
        end
    end

    generate
        if (OUTPUT_REGISTER_MODE == 1) begin : g_registered
            assign op_ready = !out_valid || out_ready;

            always_ff @(posedge clk) begin
                if (rst) begin
                    out_valid <= 1'b0;
                end else if (op_valid && op_ready) begin
                    out_valid <= 1'b1;
                end else if (out_ready) begin
                    out_valid <= 1'b0;
                end
            end

            always_ff @(posedge clk) begin
                if (op_valid && op_ready) begin
                    out_result <= next_result;
                    out_reg_addr <= op_reg_addr;
                    out_invalid <= next_invalid;
                    out_inexact <= next_inexact;
                end
            end
        end else begin : g_combinational
            assign op_ready = out_ready;
            assign out_valid = op_valid;
            assign out_result = next_result;
            assign out_reg_addr = op_reg_addr;
            assign out_invalid = next_invalid;
            assign out_inexact = next_inexact;
        end
    endgenerate

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(out_invalid && out_inexact));

endmodule

// File: fsqrt_unit.sv
`timescale 1ns/100ps

module fsqrt_unit
    import fsqrt_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input  logic      clk,
    input  logic      rst,

    input  logic      in_valid,
    output logic      in_ready,
    input  float_t    in_operand,
    input  reg_addr_t in_reg_addr,

    output logic      out_valid,
    input  logic      out_ready,
    output float_t    out_result,
    output reg_addr_t out_reg_addr,
    output logic      out_invalid,
    output logic      out_inexact
);

    logic exp_valid, exp_ready;
    exponent_t exp_exponent;
    radicand_t exp_radicand;
    operand_class_t exp_class;
    logic exp_sign;
    reg_addr_t exp_reg_addr;

    logic op_valid, op_ready;
    root_t op_root;
    logic op_sticky;
    exponent_t op_exponent;
    operand_class_t op_class;
    logic op_sign;
    reg_addr_t op_reg_addr;

    fsqrt_exponent i_exponent (
        .clk, .rst,
        .in_valid, .in_ready, .in_operand, .in_reg_addr,
        .exp_valid, .exp_ready, .exp_exponent, .exp_radicand,
        .exp_class, .exp_sign, .exp_reg_addr
    );

    fsqrt_operation i_operation (
        .clk, .rst,
        .exp_valid, .exp_ready, .exp_exponent, .exp_radicand,
        .exp_class, .exp_sign, .exp_reg_addr,
        .op_valid, .op_ready, .op_root, .op_sticky,
        .op_exponent, .op_class, .op_sign, .op_reg_addr
    );

    fsqrt_round #(
        .OUTPUT_REGISTER_MODE(OUTPUT_REGISTER_MODE)
    ) i_round (
        .clk, .rst,
        .op_valid, .op_ready, .op_root, .op_sticky,
        .op_exponent, .op_class, .op_sign, .op_reg_addr,
        .out_valid, .out_ready, .out_result, .out_reg_addr,
        .out_invalid, .out_inexact
    );

endmodule

// File: fsqrt_checker.sv
`timescale 1ns/100ps

module fsqrt_checker
    import fsqrt_pkg::*;
#(
    parameter int MAX_TESTS = 64
)(
    input  logic      clk,
    input  logic      rst,
    input  logic      out_valid,
    input  logic      out_ready,
    input  float_t    out_result,
    input  reg_addr_t out_reg_addr,
    input  logic      out_invalid,
    input  logic      out_inexact,
    output int        pass_count,
    output int        fail_count,
    output int        error_count,
    output logic      done
);

    string names [MAX_TESTS];
    float_t expected_result [MAX_TESTS];
    reg_addr_t expected_reg_addr [MAX_TESTS];
    logic expected_invalid [MAX_TESTS];
    logic expected_inexact [MAX_TESTS];

    int num_expected = 0;
    int next_index = 0;
    int passed = 0;
    int mismatched = 0;
    int unexpected = 0;
    logic open_error = 1'b0;

    assign pass_count = passed;
    assign fail_count = mismatched;
    assign error_count = unexpected + int'(open_error);
    assign done = open_error || (num_expected > 0 && next_index == num_expected);

    initial begin
        int fd;
        int fields;
        string line;
        string name;
        float_t operand, result;
        reg_addr_t reg_addr;
        logic invalid, inexact;

        fd = $fopen("fsqrt_patterns.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open fsqrt_patterns.txt for the expected values");
            open_error = 1'b1;
        end else begin
            while (!$feof(fd) && num_expected < MAX_TESTS) begin
                line = "";
                fields = 0;
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%s %h %h %h %h %h",
                                     name, operand, reg_addr, result, invalid, inexact);
                end
                if (fields == 6) begin
                    names[num_expected] = name;
                    expected_result[num_expected] = result;
                    expected_reg_addr[num_expected] = reg_addr;
                    expected_invalid[num_expected] = invalid;
                    expected_inexact[num_expected] = inexact;
                    num_expected = num_expected + 1;
                end
            end
            $fclose(fd);
        end
    end

    // values read here are the ones held before the edge, so the transfer is seen as it happens.
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (next_index >= num_expected) begin
                $display("unexpected output, result %h for reg %0d came after the last test",
                         out_result, out_reg_addr);
                unexpected = unexpected + 1;
            end else if (out_result === expected_result[next_index]
                         && out_reg_addr === expected_reg_addr[next_index]
                         && out_invalid === expected_invalid[next_index]
                         && out_inexact === expected_inexact[next_index]) begin
                $display("pass %s: result %h reg %0d flags %b%b", names[next_index],
                         out_result, out_reg_addr, out_invalid, out_inexact);
                passed = passed + 1;
                next_index = next_index + 1;
            end else begin
                $display(
                    "mismatch %s: expected %h reg %0d flags %b%b, actual %h reg %0d flags %b%b",
                    names[next_index], expected_result[next_index],
                    expected_reg_addr[next_index], expected_invalid[next_index],
                    expected_inexact[next_index],
                    out_result, out_reg_addr, out_invalid, out_inexact);
                mismatched = mismatched + 1;
                next_index = next_index + 1;
            end
        end
    end

endmodule

// File: tb_fsqrt_unit.sv
`timescale 1ns/100ps

module tb_fsqrt_unit
    import fsqrt_pkg::*;
();

    localparam int max_tests = 64;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    float_t in_operand;
    reg_addr_t in_reg_addr;
    logic out_valid;
    logic out_ready;
    float_t out_result;
    reg_addr_t out_reg_addr;
    logic out_invalid;
    logic out_inexact;

    int pass_count;
    int fail_count;
    int error_count;
    logic done;
    logic hold_ready;

    float_t operands [max_tests];
    reg_addr_t reg_addrs [max_tests];
    int num_tests = 0;
    integer seed = 32'he963c70c;

    fsqrt_unit #(
        .OUTPUT_REGISTER_MODE(1)
    ) i_dut (
        .clk, .rst,
        .in_valid, .in_ready, .in_operand, .in_reg_addr,
        .out_valid, .out_ready, .out_result, .out_reg_addr,
        .out_invalid, .out_inexact
    );

    fsqrt_checker i_checker (
        .clk, .rst,
        .out_valid, .out_ready, .out_result, .out_reg_addr,
        .out_invalid, .out_inexact,
        .pass_count, .fail_count, .error_count, .done
    );

    always #2 clk = ~clk;

    // ready is low about a third of the time, and all of the time during a stall.
    always @(negedge clk) begin
        out_ready = (($unsigned($random(seed)) % 3) != 0) && !hold_ready;
    end

    task automatic load_commands();
        int fd;
        int fields;
        string line;
        string name;
        float_t operand, result;
        reg_addr_t reg_addr;
        logic invalid, inexact;

        fd = $fopen("fsqrt_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open fsqrt_patterns.txt for the stimulus");
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                line = "";
                fields = 0;
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%s %h %h %h %h %h",
                                     name, operand, reg_addr, result, invalid, inexact);
                end
                if (fields == 6) begin
                    operands[num_tests] = operand;
                    reg_addrs[num_tests] = reg_addr;
                    num_tests = num_tests + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_command(input float_t operand, input reg_addr_t reg_addr);
        in_valid = 1'b1;
        in_operand = operand;
        in_reg_addr = reg_addr;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // holds out_ready low long enough for the operation stage to stall at its output.
    task automatic stall_output(input int cycles);
        hold_ready = 1'b1;
        repeat (cycles) @(negedge clk);
        hold_ready = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_operand = '0;
        in_reg_addr = '0;
        out_ready = 1'b0;
        hold_ready = 1'b0;

        load_commands();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (num_tests == 0) begin
            $display("no test could be read from fsqrt_patterns.txt");
        end else begin
            for (int i = 0; i < num_tests; i++) begin
                send_command(operands[i], reg_addrs[i]);
                if (i == 9) begin
                    stall_output(80);
                end else if (i % 5 == 4) begin
                    repeat (30) @(negedge clk); // let the pipeline drain now and then.
                end
            end
            wait (done);
            repeat (60) @(negedge clk); // catches results that arrive after the last test.
        end

        $display("%0d tests: %0d passed, %0d mismatched, %0d other errors",
                 num_tests, pass_count, fail_count, error_count);
        if (num_tests > 0 && pass_count == num_tests && fail_count == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (num_tests > 0);
        #((num_tests * 60 + 100) * 4);
        $display("timeout, the DUT produced too few results (%0d of %0d)",
                 pass_count + fail_count, num_tests);
        $display("tests failed");
        $finish;
    end

endmodule

// File: fsqrt_patterns.txt
# name operand reg_addr expected_result expected_invalid expected_inexact
# numbers in hex, flags as single bits, results come back in this order
sqrt_4         40800000 01 40000000 0 0
sqrt_0p25      3e800000 02 3f000000 0 0
sqrt_9         41100000 03 40400000 0 0
sqrt_1         3f800000 04 3f800000 0 0
sqrt_16        41800000 05 40800000 0 0
min_normal     00800000 06 20000000 0 0
sqrt_2         40000000 07 3fb504f3 0 1
sqrt_3         40400000 08 3fddb3d7 0 1
sqrt_0p5       3f000000 09 3f3504f3 0 1
sqrt_1em30     0da24260 0a 26901d7d 0 1
sqrt_1e30      7149f2ca 0b 58635fa9 0 1
max_normal     7f7fffff 0c 5f7fffff 0 1
pos_zero       00000000 0d 00000000 0 0
neg_zero       80000000 0e 80000000 0 0
pos_inf        7f800000 0f 7f800000 0 0
quiet_nan      7fc00001 10 7fc00000 0 0
neg_nan        ffc00000 11 7fc00000 0 0
neg_one        bf800000 12 7fc00000 1 0
neg_inf        ff800000 13 7fc00000 1 0
pos_subnormal  00400000 14 00000000 0 0
neg_subnormal  80000001 15 80000000 0 0
sqrt_2_again   40000000 00 3fb504f3 0 1

// File: fsqrt_unit.f
fsqrt_pkg.sv
fsqrt_exponent.sv
fsqrt_operation.sv
fsqrt_round.sv
fsqrt_unit.sv
fsqrt_checker.sv
tb_fsqrt_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_fsqrt_unit \
    -f fsqrt_unit.f \
    -o sim_fsqrt_unit

./obj_dir/sim_fsqrt_unit | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
